/* source/sne_bridge_pkg.sv */
/* widths and streamer count are fixed here for the whole bridge
   no module takes parameters, so a new configuration means editing this package */
package sne_bridge_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////

   // memory port and apb bus share one address and data width
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // tcdm side
   localparam int NUM_STREAMERS  = 2;
   localparam int STREAMER_IDX_W = 1;
   // byte offset inside a word, ignored when matching responses
   localparam int WORD_OFFSET_W  = 2;

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   // one slot per streamer, index 0 has priority on a tie
   typedef addr_t [NUM_STREAMERS-1:0] streamer_addr_t;
   typedef data_t [NUM_STREAMERS-1:0] streamer_data_t;

   // all ones after reset so the very first request is always seen as new
   localparam addr_t PREV_ADDR_RESET = '1;

   // apb master phases
   typedef enum logic [1:0] {
      APB_IDLE   = 2'd0,
      APB_SETUP  = 2'd1,
      APB_ACCESS = 2'd2
   } apb_state_e;

endpackage

/* source/apb_req_if.sv */
/* one latched transaction at a time between latch and apb master
   pending is a level, take is a one-cycle pulse from the master */
interface apb_req_if
   import sne_bridge_pkg::*;
();

   // transaction payload, stable while pending or busy
   addr_t addr;
   data_t wdata;
   logic  is_write;

   // latch side flag, set on accept and cleared by take
   logic  pending;

   // master side handshake
   // take is high only during the setup phase
   logic  take;
   // busy covers setup and access
   logic  busy;

   modport latch (
      output addr, wdata, is_write, pending,
      input  take, busy
   );

   modport master (
      input  addr, wdata, is_write, pending,
      output take, busy
   );

endinterface

/* source/mem_change_latch.sv */
/* the memory port has no handshake, a request is recognised only by a change
   an identical request repeated back to back is seen as one transaction */
module mem_change_latch
   import sne_bridge_pkg::*;
(
   input  logic     clk_ctrl,
   input  logic     clk_ctrl_rst_high,
   input  logic     mem_valid_i,
   input  addr_t    mem_addr_i,
   input  data_t    mem_wdata_i,
   input  logic     mem_wstrb_i,
   apb_req_if.latch req
);

   // last accepted request, compared against the live port
   addr_t prev_addr;
   data_t prev_data;
   logic  prev_is_write;

   logic  addr_changed;
   logic  data_changed;
   logic  dir_changed;
   logic  new_txn;
   logic  accept;

   //////////////////////////////////////////////////////////////////////
   // change detection
   //////////////////////////////////////////////////////////////////////

   assign addr_changed = (mem_addr_i != prev_addr);
   // write data only counts on writes
   // read data lines are don't care on this port
   assign data_changed = mem_wstrb_i && (mem_wdata_i != prev_data);
   assign dir_changed  = (mem_wstrb_i != prev_is_write);

   assign new_txn = mem_valid_i && (addr_changed || data_changed || dir_changed);

   // nothing is taken while one is queued or on the bus
   // a change seen now stays visible until it can be accepted
   assign accept = new_txn && !req.pending && !req.busy;

   //////////////////////////////////////////////////////////////////////
   // control state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_ctrl or posedge clk_ctrl_rst_high) begin
      if (clk_ctrl_rst_high) begin
         req.pending   <= 1'b0;
         prev_addr     <= PREV_ADDR_RESET;
         prev_data     <= '0;
         prev_is_write <= 1'b0;
      end else begin
         if (accept) begin
            req.pending   <= 1'b1;
            // history moves only on accept
            prev_addr     <= mem_addr_i;
            prev_data     <= mem_wdata_i;
            prev_is_write <= mem_wstrb_i;
         end else if (req.take) begin
            // master has moved into setup
            req.pending <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // payload
   //////////////////////////////////////////////////////////////////////

   // captured once per accept, held through the whole apb access
   always_ff @(posedge clk_ctrl) begin
      if (accept) begin
         req.addr     <= mem_addr_i;
         req.wdata    <= mem_wdata_i;
         req.is_write <= mem_wstrb_i;
      end
   end

endmodule

/* source/apb_master_fsm.sv */
/* single outstanding apb access, no pslverr handling
   read data is valid on mem_rdata_o only in the completion cycle */
module apb_master_fsm
   import sne_bridge_pkg::*;
(
   input  logic      clk_ctrl,
   input  logic      clk_ctrl_rst_high,
   apb_req_if.master req,
   output logic      apb_psel_o,
   output logic      apb_penable_o,
   output logic      apb_pwrite_o,
   output addr_t     apb_paddr_o,
   output data_t     apb_pwdata_o,
   input  data_t     apb_prdata_i,
   input  logic      apb_pready_i,
   output data_t     mem_rdata_o
);

   apb_state_e state_q;
   apb_state_e state_d;

   // access phase ends on this cycle's edge
   logic       done;

   //////////////////////////////////////////////////////////////////////
   // next state
   //////////////////////////////////////////////////////////////////////

   assign done = (state_q == APB_ACCESS) && apb_pready_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         APB_IDLE: begin
            // a queued transaction starts one edge after it was latched
            if (req.pending) begin
               state_d = APB_SETUP;
            end
         end
         APB_SETUP: begin
            // setup always lasts exactly one cycle
            state_d = APB_ACCESS;
         end
         APB_ACCESS: begin
            // low pready keeps us here with everything held
            if (apb_pready_i) begin
               state_d = APB_IDLE;
            end
         end
         default: begin
            state_d = APB_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_ctrl or posedge clk_ctrl_rst_high) begin
      if (clk_ctrl_rst_high) begin
         state_q <= APB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // handshake back to the latch
   //////////////////////////////////////////////////////////////////////

   // take clears pending on the edge that leaves setup
   assign req.take = (state_q == APB_SETUP);
   assign req.busy = (state_q != APB_IDLE);

   //////////////////////////////////////////////////////////////////////
   // apb outputs
   //////////////////////////////////////////////////////////////////////

   // decoded straight from state, bus is quiet in idle
   assign apb_psel_o    = req.busy;
   assign apb_penable_o = (state_q == APB_ACCESS);
   assign apb_pwrite_o  = req.busy && req.is_write;
   assign apb_paddr_o   = req.busy ? req.addr : '0;

   // write data only on writes, reads keep pwdata at zero
   assign apb_pwdata_o  = (req.busy && req.is_write) ? req.wdata : '0;

   // read data passed through combinationally when the slave completes
   assign mem_rdata_o   = (done && !req.is_write) ? apb_prdata_i : '0;

endmodule

/* source/tcdm_resp_router.sv */
/* responses carry no streamer id, routing is by word address only
   two streamers waiting on the same word both map to the lower index */
module tcdm_resp_router
   import sne_bridge_pkg::*;
(
   input  logic                     clk_ctrl,
   input  logic                     clk_ctrl_rst_high,
   input  logic [NUM_STREAMERS-1:0] tcdm_req_i,
   input  streamer_addr_t           tcdm_add_i,
   input  logic                     resp_valid_i,
   input  addr_t                    resp_addr_i,
   input  data_t                    resp_data_i,
   output logic [NUM_STREAMERS-1:0] tcdm_r_valid_o,
   output streamer_data_t           tcdm_r_data_o
);

   // last requested address of each streamer
   streamer_addr_t             last_addr;

   logic                       match_found;
   logic [STREAMER_IDX_W-1:0]  match_idx;
   logic [STREAMER_IDX_W-1:0]  fallback_idx;
   logic [STREAMER_IDX_W-1:0]  sel_idx;

   //////////////////////////////////////////////////////////////////////
   // request address memory
   //////////////////////////////////////////////////////////////////////

   // updated after the edge, so a response on the same edge sees the old one
   always_ff @(posedge clk_ctrl or posedge clk_ctrl_rst_high) begin
      if (clk_ctrl_rst_high) begin
         last_addr <= '0;
      end else begin
         for (int i = 0; i < NUM_STREAMERS; i++) begin
            if (tcdm_req_i[i]) begin
               last_addr[i] <= tcdm_add_i[i];
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // streamer selection
   //////////////////////////////////////////////////////////////////////

   // scan from the top so the lowest matching index is the one left
   always_comb begin
      match_found = 1'b0;
      match_idx   = '0;
      for (int i = NUM_STREAMERS - 1; i >= 0; i--) begin
         // byte offset bits dropped on both sides
         if (resp_addr_i[ADDR_W-1:WORD_OFFSET_W] == last_addr[i][ADDR_W-1:WORD_OFFSET_W]) begin
            match_found = 1'b1;
            match_idx   = STREAMER_IDX_W'(i);
         end
      end
   end

   // no match, pick by the address bits just above the word offset
   assign fallback_idx = resp_addr_i[WORD_OFFSET_W +: STREAMER_IDX_W];

   assign sel_idx = match_found ? match_idx : fallback_idx;

   //////////////////////////////////////////////////////////////////////
   // response outputs
   //////////////////////////////////////////////////////////////////////

   // one-cycle valid pulse toward the selected streamer
   always_ff @(posedge clk_ctrl or posedge clk_ctrl_rst_high) begin
      if (clk_ctrl_rst_high) begin
         tcdm_r_valid_o <= '0;
      end else begin
         tcdm_r_valid_o <= '0;
         if (resp_valid_i) begin
            tcdm_r_valid_o[sel_idx] <= 1'b1;
         end
      end
   end

   // data held per streamer until its next routed response
   // the other slots keep their last value
   always_ff @(posedge clk_ctrl) begin
      if (resp_valid_i) begin
         tcdm_r_data_o[sel_idx] <= resp_data_i;
      end
   end

endmodule

/* source/sne_tile_bridge.sv */
/* single clock domain, one apb access in flight at a time
   memory port requests must be held until accepted, there is no ready back */
module sne_tile_bridge
   import sne_bridge_pkg::*;
(
   input  logic                     clk_ctrl,
   input  logic                     clk_ctrl_rst_high,

   // memory style request port
   input  logic                     mem_valid_i,
   input  addr_t                    mem_addr_i,
   input  data_t                    mem_wdata_i,
   input  logic                     mem_wstrb_i,
   output data_t                    mem_rdata_o,

   // apb master toward the engine register file
   output logic                     apb_psel_o,
   output logic                     apb_penable_o,
   output logic                     apb_pwrite_o,
   output addr_t                    apb_paddr_o,
   output data_t                    apb_pwdata_o,
   input  data_t                    apb_prdata_i,
   input  logic                     apb_pready_i,

   // tcdm requests seen from the streamers, responses back to them
   input  logic [NUM_STREAMERS-1:0] tcdm_req_i,
   input  streamer_addr_t           tcdm_add_i,
   input  logic                     resp_valid_i,
   input  addr_t                    resp_addr_i,
   input  data_t                    resp_data_i,
   output logic [NUM_STREAMERS-1:0] tcdm_r_valid_o,
   output streamer_data_t           tcdm_r_data_o
);

   // latched transaction handed from latch to master
   apb_req_if u_req ();

   //////////////////////////////////////////////////////////////////////
   // memory to apb path
   //////////////////////////////////////////////////////////////////////

   mem_change_latch u_latch (
      .clk_ctrl          (clk_ctrl),
      .clk_ctrl_rst_high (clk_ctrl_rst_high),
      .mem_valid_i       (mem_valid_i),
      .mem_addr_i        (mem_addr_i),
      .mem_wdata_i       (mem_wdata_i),
      .mem_wstrb_i       (mem_wstrb_i),
      .req               (u_req)
   );

   apb_master_fsm u_apb (
      .clk_ctrl          (clk_ctrl),
      .clk_ctrl_rst_high (clk_ctrl_rst_high),
      .req               (u_req),
      .apb_psel_o        (apb_psel_o),
      .apb_penable_o     (apb_penable_o),
      .apb_pwrite_o      (apb_pwrite_o),
      .apb_paddr_o       (apb_paddr_o),
      .apb_pwdata_o      (apb_pwdata_o),
      .apb_prdata_i      (apb_prdata_i),
      .apb_pready_i      (apb_pready_i),
      .mem_rdata_o       (mem_rdata_o)
   );

   //////////////////////////////////////////////////////////////////////
   // scratchpad response path
   //////////////////////////////////////////////////////////////////////

   tcdm_resp_router u_router (
      .clk_ctrl          (clk_ctrl),
      .clk_ctrl_rst_high (clk_ctrl_rst_high),
      .tcdm_req_i        (tcdm_req_i),
      .tcdm_add_i        (tcdm_add_i),
      .resp_valid_i      (resp_valid_i),
      .resp_addr_i       (resp_addr_i),
      .resp_data_i       (resp_data_i),
      .tcdm_r_valid_o    (tcdm_r_valid_o),
      .tcdm_r_data_o     (tcdm_r_data_o)
   );

endmodule

/* bench/tb_sne_stim.svh */
/* stimulus table with hand-derived expected values, wait states are drawn at run time
   data slots of a streamer never loaded are masked out of the response checks */
`ifndef TB_SNE_STIM_SVH
`define TB_SNE_STIM_SVH

typedef enum logic {ENTRY_MEM, ENTRY_RESP} entry_kind_e;

// one row of the table
// addr and data are the memory request or the tcdm response
typedef struct packed {
   entry_kind_e kind;
   addr_t       addr;
   data_t       data;
   logic        wr;
   logic [3:0]  waits;
   data_t       prdata;
   addr_t       s0_addr;
   addr_t       s1_addr;
   // expected values
   logic        exp_access;
   data_t       exp_pwdata;
   data_t       exp_rdata;
   logic [1:0]  exp_valid;
   logic [1:0]  chk_mask;
   data_t       exp_d0;
   data_t       exp_d1;
} stim_entry_t;

localparam int NUM_ENTRIES = 11;

stim_entry_t stim_table [NUM_ENTRIES];

task automatic set_mem(input int idx, input addr_t a, input data_t d, input logic wr,
                       input data_t prd, input logic acc, input data_t pw, input data_t rd);
   stim_table[idx]            = '0;
   stim_table[idx].kind       = ENTRY_MEM;
   stim_table[idx].addr       = a;
   stim_table[idx].data       = d;
   stim_table[idx].wr         = wr;
   stim_table[idx].prdata     = prd;
   stim_table[idx].exp_access = acc;
   stim_table[idx].exp_pwdata = pw;
   stim_table[idx].exp_rdata  = rd;
endtask

task automatic set_resp(input int idx, input addr_t s0, input addr_t s1, input addr_t ra,
                        input data_t rdat, input logic [1:0] vld, input logic [1:0] mask,
                        input data_t d0, input data_t d1);
   stim_table[idx]           = '0;
   stim_table[idx].kind      = ENTRY_RESP;
   stim_table[idx].s0_addr   = s0;
   stim_table[idx].s1_addr   = s1;
   stim_table[idx].addr      = ra;
   stim_table[idx].data      = rdat;
   stim_table[idx].exp_valid = vld;
   stim_table[idx].chk_mask  = mask;
   stim_table[idx].exp_d0    = d0;
   stim_table[idx].exp_d1    = d1;
endtask

task automatic fill_table();
   //      idx addr          data          wr prdata        acc pwdata        rdata
   set_mem(0, 32'h0000_0100, 32'h1111_2222, 1, 32'h0,         1, 32'h1111_2222, 32'h0);
   // same write held, nothing new
   set_mem(1, 32'h0000_0100, 32'h1111_2222, 1, 32'h0,         0, 32'h0,         32'h0);
   // held write with new data
   set_mem(2, 32'h0000_0100, 32'h3333_4444, 1, 32'h0,         1, 32'h3333_4444, 32'h0);
   set_mem(3, 32'h0000_0104, 32'h0,         0, 32'hcafe_0001, 1, 32'h0,         32'hcafe_0001);
   // read data lines change, still the same read
   set_mem(4, 32'h0000_0104, 32'h5555_5555, 0, 32'h0,         0, 32'h0,         32'h0);
   set_mem(5, 32'h0000_0200, 32'ha5a5_5a5a, 1, 32'h0,         1, 32'ha5a5_5a5a, 32'h0);
   set_mem(6, 32'h0000_0208, 32'h0,         0, 32'h1234_5678, 1, 32'h0,         32'h1234_5678);
   //       idx s0            s1            resp addr     resp data     vld    mask
   // both match the same word, lower index wins
   set_resp(7, 32'h0000_3000, 32'h0000_3000, 32'h0000_3003, 32'hd0d0_0001, 2'b01, 2'b01,
            32'hd0d0_0001, 32'h0);
   set_resp(8, 32'h0000_3000, 32'h0000_4008, 32'h0000_400a, 32'hd1d1_0002, 2'b10, 2'b11,
            32'hd0d0_0001, 32'hd1d1_0002);
   // no match, bit 2 set
   set_resp(9, 32'h0000_3000, 32'h0000_4008, 32'h0000_5004, 32'he1e1_0003, 2'b10, 2'b11,
            32'hd0d0_0001, 32'he1e1_0003);
   // no match, bit 2 clear
   set_resp(10, 32'h0000_3000, 32'h0000_4008, 32'h0000_6010, 32'he0e0_0004, 2'b01, 2'b11,
            32'he0e0_0004, 32'he1e1_0003);
endtask

`endif

/* bench/tb_sne_tile_bridge.sv */
/* table driven bench with an in-bench apb slave, wait states come from a fixed seed
   the memory request stays held between entries, as the bridge has no ready */
module tb_sne_tile_bridge
   import sne_bridge_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;
   // give up on an access after this many low pready cycles
   localparam int ACCESS_GUARD = 16;

   logic                     clk_ctrl;
   logic                     clk_ctrl_rst_high;
   logic                     mem_valid_i;
   addr_t                    mem_addr_i;
   data_t                    mem_wdata_i;
   logic                     mem_wstrb_i;
   data_t                    mem_rdata_o;
   logic                     apb_psel_o;
   logic                     apb_penable_o;
   logic                     apb_pwrite_o;
   addr_t                    apb_paddr_o;
   data_t                    apb_pwdata_o;
   data_t                    apb_prdata_i;
   logic                     apb_pready_i;
   logic [NUM_STREAMERS-1:0] tcdm_req_i;
   streamer_addr_t           tcdm_add_i;
   logic                     resp_valid_i;
   addr_t                    resp_addr_i;
   data_t                    resp_data_i;
   logic [NUM_STREAMERS-1:0] tcdm_r_valid_o;
   streamer_data_t           tcdm_r_data_o;

   `include "tb_sne_stim.svh"

   integer seed = 32'h4f26;
   int     err_count;
   int     check_count;
   int     errs_before;
   // slave model state
   int     cur_waits;
   data_t  cur_prdata;
   int     wait_left;

   sne_tile_bridge DUT (
      .clk_ctrl          (clk_ctrl),
      .clk_ctrl_rst_high (clk_ctrl_rst_high),
      .mem_valid_i       (mem_valid_i),
      .mem_addr_i        (mem_addr_i),
      .mem_wdata_i       (mem_wdata_i),
      .mem_wstrb_i       (mem_wstrb_i),
      .mem_rdata_o       (mem_rdata_o),
      .apb_psel_o        (apb_psel_o),
      .apb_penable_o     (apb_penable_o),
      .apb_pwrite_o      (apb_pwrite_o),
      .apb_paddr_o       (apb_paddr_o),
      .apb_pwdata_o      (apb_pwdata_o),
      .apb_prdata_i      (apb_prdata_i),
      .apb_pready_i      (apb_pready_i),
      .tcdm_req_i        (tcdm_req_i),
      .tcdm_add_i        (tcdm_add_i),
      .resp_valid_i      (resp_valid_i),
      .resp_addr_i       (resp_addr_i),
      .resp_data_i       (resp_data_i),
      .tcdm_r_valid_o    (tcdm_r_valid_o),
      .tcdm_r_data_o     (tcdm_r_data_o)
   );

   initial begin
      clk_ctrl = 1'b0;
      forever #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;
   end

   //////////////////////////////////////////////////////////////////////
   // apb slave model
   //////////////////////////////////////////////////////////////////////

   // pready rises after cur_waits low cycles of the access phase
   always @(posedge clk_ctrl) begin
      if (apb_psel_o && !apb_penable_o) begin
         wait_left    <= cur_waits;
         apb_pready_i <= (cur_waits == 0);
         apb_prdata_i <= cur_prdata;
      end else if (apb_psel_o && apb_penable_o && !apb_pready_i) begin
         wait_left    <= wait_left - 1;
         apb_pready_i <= (wait_left == 1);
      end else begin
         apb_pready_i <= 1'b0;
      end
   end

   // run limit scales with the table
   initial begin
      repeat (RESET_CYCLES + NUM_ENTRIES * 40) @(posedge clk_ctrl);
      $display("watchdog expired, the table did not complete in time");
      $display("Verification failed");
      $finish;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("Fail time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
         err_count++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory port entry
   //////////////////////////////////////////////////////////////////////

   task automatic run_mem(input stim_entry_t e);
      int waited;
      @(posedge clk_ctrl);
      mem_valid_i <= 1'b1;
      mem_addr_i  <= e.addr;
      mem_wdata_i <= e.data;
      mem_wstrb_i <= e.wr;
      cur_waits   <= e.waits;
      cur_prdata  <= e.prdata;
      // second negedge sits just after the sampling edge
      repeat (2) @(negedge clk_ctrl);
      check_value("apb_psel_o", apb_psel_o, 1'b0);
      if (!e.exp_access) begin
         // no access may start while the request is held
         repeat (4) begin
            @(negedge clk_ctrl);
            check_value("apb_psel_o", apb_psel_o, 1'b0);
         end
      end else begin
         // setup phase, two edges after sampling
         @(negedge clk_ctrl);
         check_value("apb_psel_o", apb_psel_o, 1'b1);
         check_value("apb_penable_o", apb_penable_o, 1'b0);
         check_value("apb_paddr_o", apb_paddr_o, e.addr);
         check_value("apb_pwrite_o", apb_pwrite_o, e.wr);
         check_value("apb_pwdata_o", apb_pwdata_o, e.exp_pwdata);
         @(negedge clk_ctrl);
         waited = 0;
         while (!apb_pready_i && waited < ACCESS_GUARD) begin
            // held stable through wait states
            check_value("apb_penable_o", apb_penable_o, 1'b1);
            check_value("apb_paddr_o", apb_paddr_o, e.addr);
            check_value("apb_pwrite_o", apb_pwrite_o, e.wr);
            check_value("apb_pwdata_o", apb_pwdata_o, e.exp_pwdata);
            check_value("mem_rdata_o", mem_rdata_o, 32'h0);
            waited++;
            @(negedge clk_ctrl);
         end
         if (!apb_pready_i) begin
            $display("access at time %0t never saw pready from the slave model", $time);
            err_count++;
         end
         check_value("wait_cycles", waited, e.waits);
         // completion cycle
         check_value("apb_penable_o", apb_penable_o, 1'b1);
         check_value("apb_paddr_o", apb_paddr_o, e.addr);
         check_value("apb_pwdata_o", apb_pwdata_o, e.exp_pwdata);
         check_value("mem_rdata_o", mem_rdata_o, e.exp_rdata);
         @(negedge clk_ctrl);
         check_value("apb_psel_o", apb_psel_o, 1'b0);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // tcdm response entry
   //////////////////////////////////////////////////////////////////////

   task automatic run_resp(input stim_entry_t e);
      @(posedge clk_ctrl);
      tcdm_req_i    <= 2'b11;
      tcdm_add_i[0] <= e.s0_addr;
      tcdm_add_i[1] <= e.s1_addr;
      @(posedge clk_ctrl);
      tcdm_req_i   <= 2'b00;
      resp_valid_i <= 1'b1;
      resp_addr_i  <= e.addr;
      resp_data_i  <= e.data;
      @(negedge clk_ctrl);
      check_value("tcdm_r_valid_o", tcdm_r_valid_o, 2'b00);
      @(posedge clk_ctrl);
      resp_valid_i <= 1'b0;
      // pulse one edge after the response
      @(negedge clk_ctrl);
      check_value("tcdm_r_valid_o", tcdm_r_valid_o, e.exp_valid);
      if (e.chk_mask[0]) begin
         check_value("tcdm_r_data_o[0]", tcdm_r_data_o[0], e.exp_d0);
      end
      if (e.chk_mask[1]) begin
         check_value("tcdm_r_data_o[1]", tcdm_r_data_o[1], e.exp_d1);
      end
      @(negedge clk_ctrl);
      check_value("tcdm_r_valid_o", tcdm_r_valid_o, 2'b00);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      err_count         = 0;
      check_count       = 0;
      clk_ctrl_rst_high = 1'b1;
      mem_valid_i       = 1'b0;
      mem_addr_i        = '0;
      mem_wdata_i       = '0;
      mem_wstrb_i       = 1'b0;
      apb_prdata_i      = '0;
      apb_pready_i      = 1'b0;
      tcdm_req_i        = '0;
      tcdm_add_i        = '0;
      resp_valid_i      = 1'b0;
      resp_addr_i       = '0;
      resp_data_i       = '0;
      cur_waits         = 0;
      cur_prdata        = '0;
      wait_left         = 0;
      fill_table();
      // odd rows always get at least one wait state
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         stim_table[i].waits = 4'((i % 2) + ($unsigned($random(seed)) % 3));
      end
      repeat (RESET_CYCLES) @(posedge clk_ctrl);
      @(negedge clk_ctrl);
      check_value("apb_psel_o", apb_psel_o, 1'b0);
      check_value("apb_penable_o", apb_penable_o, 1'b0);
      check_value("apb_pwrite_o", apb_pwrite_o, 1'b0);
      check_value("tcdm_r_valid_o", tcdm_r_valid_o, 2'b00);
      @(posedge clk_ctrl);
      clk_ctrl_rst_high <= 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         errs_before = err_count;
         if (stim_table[i].kind == ENTRY_MEM) begin
            run_mem(stim_table[i]);
         end else begin
            run_resp(stim_table[i]);
         end
         $display("test %0d %s waits=%0d: %s", i,
                  (stim_table[i].kind == ENTRY_MEM) ? "mem" : "resp",
                  stim_table[i].waits, (err_count == errs_before) ? "ok" : "mismatch");
      end
      $display("%0d tests, %0d checks, %0d errors", NUM_ENTRIES, check_count, err_count);
      if (err_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+bench
source/sne_bridge_pkg.sv
source/apb_req_if.sv
source/mem_change_latch.sv
source/apb_master_fsm.sv
source/tcdm_resp_router.sv
source/sne_tile_bridge.sv
bench/tb_sne_tile_bridge.sv
